// ==== rename_stage.f ====
source/rename_pkg.sv
source/free_list.sv
source/rename_map.sv
source/retire_map.sv
source/rename_stage.sv
testbench/tb_clock.sv
testbench/tb_rename_stage.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_rename_stage
RTL_TOP    ?= rename_stage
FILELIST   ?= rename_stage.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing --timescale 1ns/1ps -Wno-fatal

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter source/%,$(SRCS))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_rename_stage.sv ====
module tb_rename_stage;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ARCH       = 32;
    localparam int NUM_PHYS       = 64;
    localparam int DEPTH          = NUM_PHYS - NUM_ARCH;
    localparam int TIMEOUT_CYCLES = 20;

    logic                    clk;
    logic                    rst;
    logic                    rename_valid;
    rename_pkg::rename_req_t rename_req;
    rename_pkg::rename_rsp_t rename_rsp;
    logic                    rename_stall;
    logic                    commit_valid;
    rename_pkg::commit_t     commit;
    logic                    release_overflow;

    integer seed;

    // reference model of both maps and the free FIFO
    rename_pkg::phys_tag_t spec_map [NUM_ARCH];
    rename_pkg::phys_tag_t ret_map [NUM_ARCH];
    rename_pkg::phys_tag_t free_q [$];
    rename_pkg::commit_t   pending [$];  // renamed, waiting to commit, program order
    logic                  model_overflow;

    tb_clock i_clock (.clk(clk));

    rename_stage #(
        .NUM_ARCH (NUM_ARCH),
        .NUM_PHYS (NUM_PHYS)
    ) i_rename_stage (
        .clk              (clk),
        .rst              (rst),
        .rename_valid     (rename_valid),
        .rename_req       (rename_req),
        .rename_rsp       (rename_rsp),
        .rename_stall     (rename_stall),
        .commit_valid     (commit_valid),
        .commit           (commit),
        .release_overflow (release_overflow)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("error %s actual 0x%0h expected 0x%0h", name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic apply_reset();
        rst          = 1'b1;
        rename_valid = 1'b0;
        commit_valid = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        // identity maps, free tags NUM_ARCH.. in order
        for (int i = 0; i < NUM_ARCH; i++)
        begin
            spec_map[i] = rename_pkg::phys_tag_t'(i);
            ret_map[i]  = rename_pkg::phys_tag_t'(i);
        end
        free_q.delete();
        for (int i = 0; i < DEPTH; i++)
        begin
            free_q.push_back(rename_pkg::phys_tag_t'(NUM_ARCH + i));
        end
        pending.delete();
        model_overflow = 1'b0;
    endtask

    // one clock cycle: drive, check the combinational response, step the model
    task automatic drive_cycle(input logic do_rename, input rename_pkg::rename_req_t req,
                               input logic do_commit, input rename_pkg::commit_t cm);
        logic                  exp_stall;
        logic                  alloc;
        logic                  rel;
        logic                  was_full;
        rename_pkg::phys_tag_t rel_tag;
        rename_pkg::commit_t   entry;
        rename_valid = do_rename;
        rename_req   = req;
        commit_valid = do_commit;
        commit       = cm;
        #1;
        exp_stall = do_rename && (req.rd != '0) && (free_q.size() == 0);
        alloc     = do_rename && (req.rd != '0) && !exp_stall;
        rel       = do_commit && (cm.rd != '0);
        was_full  = (free_q.size() == DEPTH);  // pointers before the edge
        check_value("rename_stall", rename_stall, exp_stall);
        check_value("release_overflow", release_overflow, model_overflow);
        if (do_rename && !exp_stall)
        begin
            check_value("src1_tag", rename_rsp.src1_tag, spec_map[req.rs1]);
            check_value("src2_tag", rename_rsp.src2_tag, spec_map[req.rs2]);
            check_value("dst_tag", rename_rsp.dst_tag, alloc ? free_q[0] : '0);
            check_value("old_tag", rename_rsp.old_tag, alloc ? spec_map[req.rd] : '0);
        end
        if (rel)
        begin
            rel_tag         = ret_map[cm.rd];  // retired tag goes free
            ret_map[cm.rd]  = cm.tag;
        end
        if (alloc)
        begin
            spec_map[req.rd] = free_q.pop_front();
            entry.rd         = req.rd;
            entry.tag        = spec_map[req.rd];
            pending.push_back(entry);
        end
        if (rel && was_full)
            model_overflow = 1'b1;  // release dropped
        else if (rel)
            free_q.push_back(rel_tag);
        @(posedge clk);
        #1;
        rename_valid = 1'b0;
        commit_valid = 1'b0;
    endtask

    // hold a rename until the stall drops
    task automatic wait_stall_low(input rename_pkg::rename_req_t req, output int waited);
        rename_valid = 1'b1;
        rename_req   = req;
        commit_valid = 1'b0;
        waited       = 0;
        #1;
        while (rename_stall)
        begin
            if (waited >= TIMEOUT_CYCLES)
            begin
                $display("timeout while waiting for rename_stall to drop");
                $display("TESTBENCH FAILED");
                $fatal(1, "stall never released");
            end
            @(posedge clk);
            #2;  // mid cycle, inputs unchanged
            waited++;
        end
    endtask

    // identity reads, tags handed out from 32 upward
    task automatic rename_after_reset();
        rename_pkg::rename_req_t req;
        check_value("rename_stall", rename_stall, 1'b0);
        check_value("release_overflow", release_overflow, 1'b0);
        for (int i = 1; i <= 4; i++)
        begin
            req.rs1 = rename_pkg::arch_reg_t'(i + 10);
            req.rs2 = rename_pkg::arch_reg_t'(i + 20);
            req.rd  = rename_pkg::arch_reg_t'(i);
            drive_cycle(1'b1, req, 1'b0, '0);
        end
    endtask

    // new tag visible next cycle, old tag reported
    task automatic map_update_visible();
        rename_pkg::rename_req_t req;
        req = '{rs1: 5'd3, rs2: 5'd4, rd: 5'd5};
        drive_cycle(1'b1, req, 1'b0, '0);
        req = '{rs1: 5'd5, rs2: 5'd5, rd: 5'd5};  // reads and rewrites x5
        drive_cycle(1'b1, req, 1'b0, '0);
        drive_cycle(1'b1, req, 1'b0, '0);
    endtask

    task automatic x0_rename();
        rename_pkg::rename_req_t req;
        req = '{rs1: 5'd0, rs2: 5'd0, rd: 5'd0};
        drive_cycle(1'b1, req, 1'b0, '0);
        drive_cycle(1'b1, req, 1'b0, '0);
        req = '{rs1: 5'd0, rs2: 5'd5, rd: 5'd9};  // gets the next tag in line
        drive_cycle(1'b1, req, 1'b0, '0);
    endtask

    // drain the list, then a held rename must stall
    task automatic drain_free_list();
        rename_pkg::rename_req_t req;
        for (int k = 0; k < NUM_PHYS && free_q.size() > 0; k++)
        begin
            req.rs1 = rename_pkg::arch_reg_t'(k % 32);
            req.rs2 = rename_pkg::arch_reg_t'((k + 7) % 32);
            req.rd  = rename_pkg::arch_reg_t'(1 + (k % 31));
            drive_cycle(1'b1, req, 1'b0, '0);
        end
        req = '{rs1: 5'd7, rs2: 5'd2, rd: 5'd7};
        drive_cycle(1'b1, req, 1'b0, '0);  // stalled
        drive_cycle(1'b1, req, 1'b0, '0);  // still held
        req = '{rs1: 5'd7, rs2: 5'd7, rd: 5'd0};  // x7 mapping untouched
        drive_cycle(1'b1, req, 1'b0, '0);
    endtask

    task automatic commit_and_reuse();
        rename_pkg::rename_req_t req;
        rename_pkg::rename_req_t held;
        rename_pkg::commit_t     cm;
        logic                    do_commit;
        logic [31:0]             r;
        int                      waited;
        held = '{rs1: 5'd7, rs2: 5'd2, rd: 5'd7};
        drive_cycle(1'b1, held, 1'b1, pending.pop_front());  // stall while freeing
        wait_stall_low(held, waited);
        check_value("stall_cycles", waited, 0);
        drive_cycle(1'b1, held, 1'b0, '0);  // takes the released tag
        for (int n = 0; n < 40; n++)
        begin
            r       = $random(seed);
            req.rs1 = r[4:0];
            req.rs2 = r[9:5];
            req.rd  = rename_pkg::arch_reg_t'(1 + (r[20:16] % 31));
            do_commit = (pending.size() > 0);
            cm        = do_commit ? pending.pop_front() : '0;
            // rename only with a free tag, alloc and release then share the cycle
            drive_cycle(free_q.size() > 0, req, do_commit, cm);
        end
    endtask

    // commit right after reset finds the list full
    task automatic release_when_full();
        rename_pkg::commit_t cm;
        apply_reset();
        cm = '{rd: 5'd3, tag: 6'd40};
        drive_cycle(1'b0, '0, 1'b1, cm);
        repeat (3) drive_cycle(1'b0, '0, 1'b0, '0);  // flag holds
        check_value("release_overflow", release_overflow, 1'b1);
    endtask

    initial
    begin
        seed         = 32'h78;
        rst          = 1'b1;
        rename_valid = 1'b0;
        rename_req   = '0;
        commit_valid = 1'b0;
        commit       = '0;
        apply_reset();
        rename_after_reset();
        map_update_visible();
        x0_rename();
        drain_free_list();
        commit_and_reuse();
        release_when_full();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== testbench/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD = 4  // ns
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;  // free running
    end

endmodule

// ==== source/rename_stage.sv ====
module rename_stage #(
    parameter int NUM_ARCH = 32,
    parameter int NUM_PHYS = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rename_valid,
    input  rename_pkg::rename_req_t rename_req,
    output rename_pkg::rename_rsp_t rename_rsp,
    output logic                    rename_stall,
    input  logic                    commit_valid,
    input  rename_pkg::commit_t     commit,
    output logic                    release_overflow
);

    // free tags are whatever the architectural set does not hold at reset
    localparam int DEPTH = NUM_PHYS - NUM_ARCH;

    logic                  rd_nonzero;
    logic                  alloc;
    logic                  fl_empty;
    rename_pkg::phys_tag_t alloc_tag;
    rename_pkg::phys_tag_t map_old_tag;
    logic                  release_en;
    rename_pkg::phys_tag_t release_tag;

    assign rd_nonzero = (rename_req.rd != '0);

    // stall only when a real destination finds no free tag
    assign rename_stall = rename_valid && rd_nonzero && fl_empty;
    assign alloc        = rename_valid && rd_nonzero && !fl_empty;

    // x0 bypass, no tag taken and nothing reported as old
    assign rename_rsp.dst_tag = rd_nonzero ? alloc_tag : '0;
    assign rename_rsp.old_tag = rd_nonzero ? map_old_tag : '0;

    rename_map #(
        .NUM_ARCH (NUM_ARCH)
    ) i_rename_map (
        .clk       (clk),
        .rst       (rst),
        .rs1       (rename_req.rs1),
        .rs2       (rename_req.rs2),
        .rd        (rename_req.rd),
        .src1_tag  (rename_rsp.src1_tag),
        .src2_tag  (rename_rsp.src2_tag),
        .old_tag   (map_old_tag),
        .write     (alloc),      // map written only when a tag is taken
        .write_tag (alloc_tag)
    );

    free_list #(
        .DEPTH (DEPTH)
    ) i_free_list (
        .clk         (clk),
        .rst         (rst),
        .alloc       (alloc),
        .alloc_tag   (alloc_tag),
        .release_en  (release_en),
        .release_tag (release_tag),
        .empty       (fl_empty),
        .overflow    (release_overflow)
    );

    // commit path, retired mapping frees the tag it replaces
    retire_map #(
        .NUM_ARCH (NUM_ARCH)
    ) i_retire_map (
        .clk          (clk),
        .rst          (rst),
        .commit_valid (commit_valid),
        .commit       (commit),
        .release_en   (release_en),
        .release_tag  (release_tag)
    );

endmodule

// ==== source/retire_map.sv ====
module retire_map #(
    parameter int NUM_ARCH = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  commit_valid,
    input  rename_pkg::commit_t   commit,
    output logic                  release_en,   // a tag goes back to the free list
    output rename_pkg::phys_tag_t release_tag   // tag the committed rd held
);

    // architectural state as of the last commit
    rename_pkg::phys_tag_t map_q [NUM_ARCH];

    // x0 never frees anything
    assign release_en  = commit_valid && (commit.rd != '0);
    assign release_tag = map_q[commit.rd];  // previous committed mapping

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_ARCH; i++)
            begin
                map_q[i] <= rename_pkg::phys_tag_t'(i);  // identity after reset
            end
        end
        else if (release_en)
        begin
            map_q[commit.rd] <= commit.tag;  // new tag becomes committed
        end
    end

endmodule

// ==== source/rename_map.sv ====
module rename_map #(
    parameter int NUM_ARCH = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  rename_pkg::arch_reg_t rs1,
    input  rename_pkg::arch_reg_t rs2,
    input  rename_pkg::arch_reg_t rd,
    output rename_pkg::phys_tag_t src1_tag,
    output rename_pkg::phys_tag_t src2_tag,
    output rename_pkg::phys_tag_t old_tag,
    input  logic                  write,      // allocation for rd this cycle
    input  rename_pkg::phys_tag_t write_tag   // newly allocated tag
);

    // speculative arch -> phys table
    rename_pkg::phys_tag_t map_q [NUM_ARCH];

    logic write_ok;

    // x0 entry is never overwritten
    assign write_ok = write && (rd != '0);

    // three asynchronous read ports, from current state
    assign src1_tag = map_q[rs1];
    assign src2_tag = map_q[rs2];
    assign old_tag  = map_q[rd];  // mapping that rd is about to lose

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // identity mapping, xN -> tag N
            for (int i = 0; i < NUM_ARCH; i++)
            begin
                map_q[i] <= rename_pkg::phys_tag_t'(i);
            end
        end
        else if (write_ok)
        begin
            map_q[rd] <= write_tag;  // seen by sources next cycle
        end
    end

endmodule

// ==== source/free_list.sv ====
module free_list #(
    parameter int DEPTH = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 alloc,        // take the head tag this cycle
    output rename_pkg::phys_tag_t alloc_tag,    // head tag, combinational
    input  logic                 release_en,   // return a tag this cycle
    input  rename_pkg::phys_tag_t release_tag,
    output logic                 empty,
    output logic                 overflow      // sticky, release seen while full
);

    localparam int IDX_W = $clog2(DEPTH);

    // pointers carry one extra wrap bit above the index
    logic [IDX_W:0] head_q;
    logic [IDX_W:0] tail_q;

    rename_pkg::phys_tag_t mem [DEPTH];  // circular tag storage

    logic full;
    logic alloc_ok;    // allocate actually served
    logic release_ok;  // release actually stored

    // advance a pointer by one, wrapping at DEPTH and flipping the wrap bit
    // handles depths that are not a power of two
    function automatic logic [IDX_W:0] ptr_inc(input logic [IDX_W:0] ptr);
        logic [IDX_W:0] nxt;
        nxt = ptr;
        if (ptr[IDX_W-1:0] == IDX_W'(DEPTH - 1))
        begin
            nxt[IDX_W-1:0] = '0;
            nxt[IDX_W]     = ~ptr[IDX_W];  // lap completed
        end
        else
        begin
            nxt[IDX_W-1:0] = ptr[IDX_W-1:0] + 1'b1;
        end
        return nxt;
    endfunction

    // same index: wrap bits tell full from empty
    assign empty = (head_q[IDX_W-1:0] == tail_q[IDX_W-1:0])
                && (head_q[IDX_W] == tail_q[IDX_W]);
    assign full  = (head_q[IDX_W-1:0] == tail_q[IDX_W-1:0])
                && (head_q[IDX_W] != tail_q[IDX_W]);

    assign alloc_ok   = alloc && !empty;
    assign release_ok = release_en && !full;  // dropped when no room

    assign alloc_tag = mem[head_q[IDX_W-1:0]];  // head presented every cycle

    // pointers and sticky flag
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            head_q   <= '0;
            tail_q   <= {1'b1, {IDX_W{1'b0}}};  // one lap ahead, list full
            overflow <= 1'b0;
        end
        else
        begin
            if (alloc_ok)
            begin
                head_q <= ptr_inc(head_q);
            end
            if (release_ok)
            begin
                tail_q <= ptr_inc(tail_q);
            end
            if (release_en && full)
            begin
                overflow <= 1'b1;  // stays set until reset
            end
        end
    end

    // storage, preloaded with the tags above the architectural range
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                mem[i] <= rename_pkg::phys_tag_t'(DEPTH + i);  // ascending order
            end
        end
        else if (release_ok)
        begin
            mem[tail_q[IDX_W-1:0]] <= release_tag;  // freed tag goes to tail
        end
    end

endmodule

// ==== source/rename_pkg.sv ====
package rename_pkg;

    // widths of the two index spaces
    localparam int ARCH_REG_W = 5;  // x0..x31
    localparam int PHYS_TAG_W = 6;  // enough for 64 physical regs

    // architectural register index
    typedef logic [ARCH_REG_W-1:0] arch_reg_t;

    // physical register tag
    typedef logic [PHYS_TAG_W-1:0] phys_tag_t;

    // fields of one instruction to rename
    typedef struct packed {
        arch_reg_t rs1;  // first source
        arch_reg_t rs2;  // second source
        arch_reg_t rd;   // destination
    } rename_req_t;

    // rename result, valid in the request cycle
    typedef struct packed {
        phys_tag_t src1_tag;  // current mapping of rs1
        phys_tag_t src2_tag;  // current mapping of rs2
        phys_tag_t dst_tag;   // newly allocated tag for rd
        phys_tag_t old_tag;   // tag rd held before this rename
    } rename_rsp_t;

    // one retiring destination
    typedef struct packed {
        arch_reg_t rd;   // committed destination
        phys_tag_t tag;  // tag allocated to rd at rename
    } commit_t;

endpackage
